// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_event_window
RTL_TOP    := event_window_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/100ps -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --top-module $(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: event_geom_pkg.sv
`default_nettype none

package event_geom_pkg;

    // Pixel address is {row, col}, one byte each
    localparam int coord_width = 8;
    localparam int addr_width  = 2 * coord_width;

    // Columns held by one row slot
    localparam int num_cols = 1 << coord_width;

    typedef logic [coord_width-1:0] coord_t;

    // Payload carried by each sensor event
    localparam int default_data_width = 46;

endpackage

`default_nettype wire

// File: event_window_top.sv
`timescale 1ns/100ps
`default_nettype none

module event_window_top #(
    parameter int  DATA_WIDTH  = event_geom_pkg::default_data_width,
    parameter int  HALF_WINDOW = window_pkg::default_half_window,
    localparam int WINDOW_SIZE = 2 * HALF_WINDOW + 1
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  event_valid,
    input  wire [DATA_WIDTH-1:0]                 event_value,
    input  wire [event_geom_pkg::addr_width-1:0] event_addr,
    output logic                                 event_ready,
    output logic                                 write_done,
    output logic                                 event_dropped,
    input  wire                                  read_req,
    input  wire [event_geom_pkg::addr_width-1:0] read_addr,
    output logic [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] window_value,
    output logic                                 window_valid
);

    localparam int SLOT_WIDTH = $clog2(WINDOW_SIZE);

    logic                   advance;
    event_geom_pkg::coord_t base_row;
    logic [SLOT_WIDTH-1:0]  head_slot;
    logic                   wr_en;
    logic [SLOT_WIDTH-1:0]  wr_slot;
    event_geom_pkg::coord_t wr_col;
    logic [DATA_WIDTH-1:0]  wr_value;
    logic                   clr_en;
    logic [SLOT_WIDTH-1:0]  clr_slot;
    event_geom_pkg::coord_t rd_col;
    logic [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] rd_rows;

    //////////////////////////////
    // Band position
    //////////////////////////////

    row_base_counter #(
        .HALF_WINDOW (HALF_WINDOW)
    ) u_row_base_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .base_row  (base_row),
        .head_slot (head_slot)
    );

    //////////////////////////////
    // Event write path
    //////////////////////////////

    write_fsm #(
        .DATA_WIDTH  (DATA_WIDTH),
        .HALF_WINDOW (HALF_WINDOW)
    ) u_write_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .event_valid   (event_valid),
        .event_value   (event_value),
        .event_addr    (event_addr),
        .event_ready   (event_ready),
        .base_row      (base_row),
        .head_slot     (head_slot),
        .advance       (advance),
        .wr_en         (wr_en),
        .wr_slot       (wr_slot),
        .wr_col        (wr_col),
        .wr_value      (wr_value),
        .clr_en        (clr_en),
        .clr_slot      (clr_slot),
        .write_done    (write_done),
        .event_dropped (event_dropped)
    );

    row_ring_buffer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .HALF_WINDOW (HALF_WINDOW)
    ) u_row_ring_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_slot  (wr_slot),
        .wr_col   (wr_col),
        .wr_value (wr_value),
        .clr_en   (clr_en),
        .clr_slot (clr_slot),
        .rd_col   (rd_col),
        .rd_rows  (rd_rows)
    );

    // Window read path
    window_gather #(
        .DATA_WIDTH  (DATA_WIDTH),
        .HALF_WINDOW (HALF_WINDOW)
    ) u_window_gather (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_req     (read_req),
        .read_addr    (read_addr),
        .base_row     (base_row),
        .head_slot    (head_slot),
        .rd_rows      (rd_rows),
        .rd_col       (rd_col),
        .window_value (window_value),
        .window_valid (window_valid)
    );

endmodule

`default_nettype wire

// File: row_base_counter.sv
`timescale 1ns/100ps
`default_nettype none

module row_base_counter #(
    parameter int  HALF_WINDOW = window_pkg::default_half_window,
    localparam int WINDOW_SIZE = 2 * HALF_WINDOW + 1,
    localparam int SLOT_WIDTH  = $clog2(WINDOW_SIZE)
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     advance,
    output event_geom_pkg::coord_t  base_row,
    output logic [SLOT_WIDTH-1:0]   head_slot
);

    localparam event_geom_pkg::coord_t LAST_BASE =
        event_geom_pkg::coord_t'(window_pkg::max_base_row);
    localparam logic [SLOT_WIDTH-1:0] LAST_SLOT = SLOT_WIDTH'(WINDOW_SIZE - 1);

    // head_slot tracks the slot that holds base_row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_row  <= '0;
            head_slot <= '0;
        end else if (advance && base_row != LAST_BASE) begin
            base_row <= base_row + event_geom_pkg::coord_t'(1);
            if (head_slot == LAST_SLOT) begin
                head_slot <= '0;
            end else begin
                head_slot <= head_slot + SLOT_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: row_ring_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module row_ring_buffer #(
    parameter int  DATA_WIDTH  = event_geom_pkg::default_data_width,
    parameter int  HALF_WINDOW = window_pkg::default_half_window,
    localparam int WINDOW_SIZE = 2 * HALF_WINDOW + 1,
    localparam int SLOT_WIDTH  = $clog2(WINDOW_SIZE)
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          wr_en,
    input  wire [SLOT_WIDTH-1:0]         wr_slot,
    input  wire event_geom_pkg::coord_t  wr_col,
    input  wire [DATA_WIDTH-1:0]         wr_value,
    input  wire                          clr_en,
    input  wire [SLOT_WIDTH-1:0]         clr_slot,
    input  wire event_geom_pkg::coord_t  rd_col,
    // Slot s, column offset k at rd_rows[s][k], entry [0][0] in the top bits
    output logic [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] rd_rows
);

    localparam int NUM_COLS = event_geom_pkg::num_cols;
    localparam int CW       = event_geom_pkg::coord_width;

    logic [DATA_WIDTH-1:0] mem [WINDOW_SIZE][NUM_COLS];

    // Clear and write never share a cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < WINDOW_SIZE; s++) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    mem[s][c] <= '0;
                end
            end
        end else begin
            for (int s = 0; s < WINDOW_SIZE; s++) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    if (clr_en && clr_slot == SLOT_WIDTH'(s)) begin
                        mem[s][c] <= '0;
                    end else if (wr_en && wr_slot == SLOT_WIDTH'(s) &&
                                 wr_col == event_geom_pkg::coord_t'(c)) begin
                        mem[s][c] <= wr_value;
                    end
                end
            end
        end
    end

    // Neighborhood columns of every slot, zero past either edge
    always_comb begin
        int col;
        col = 0;
        for (int s = 0; s < WINDOW_SIZE; s++) begin
            for (int k = 0; k < WINDOW_SIZE; k++) begin
                col = int'(rd_col) - HALF_WINDOW + k;
                if (col >= 0 && col < NUM_COLS) begin
                    rd_rows[s][k] = mem[s][col[CW-1:0]];
                end else begin
                    rd_rows[s][k] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_event_window.sv
`timescale 1ns/100ps
`default_nettype none

module tb_event_window;

    localparam int dw         = event_geom_pkg::default_data_width;
    localparam int hw         = window_pkg::default_half_window;
    localparam int ws         = 2 * hw + 1;
    localparam int num_cols   = event_geom_pkg::num_cols;
    localparam int num_rows   = 1 << event_geom_pkg::coord_width;
    localparam int max_base   = window_pkg::max_base_row;
    localparam int clk_period = 10;

    // Run length from events, band advances and reads, plus margin
    localparam int event_count     = 19;
    localparam int event_cycles    = 8;
    localparam int read_count      = 33;
    localparam int watchdog_cycles = 4 + event_count * event_cycles + max_base
                                     + read_count * 2 + 200;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  event_valid;
    logic [dw-1:0]                         event_value;
    logic [event_geom_pkg::addr_width-1:0] event_addr;
    logic                                  event_ready;
    logic                                  write_done;
    logic                                  event_dropped;
    logic                                  read_req;
    logic [event_geom_pkg::addr_width-1:0] read_addr;
    logic [0:ws-1][0:ws-1][dw-1:0]         window_value;
    logic                                  window_valid;

    int error_count;
    int check_count;

    // Reference model of the sensor map and the band
    logic [dw-1:0] model_mem [0:num_rows-1][0:num_cols-1];
    int            model_base;
    int            adv_col;

    event_window_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .event_valid   (event_valid),
        .event_value   (event_value),
        .event_addr    (event_addr),
        .event_ready   (event_ready),
        .write_done    (write_done),
        .event_dropped (event_dropped),
        .read_req      (read_req),
        .read_addr     (read_addr),
        .window_value  (window_value),
        .window_valid  (window_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t",
                     name, got, expected, $time);
        end
    endtask

    function automatic logic [dw-1:0] rand_value();
        logic [63:0] raw;
        raw = {$urandom(), $urandom()};
        // Zero would hide a missing write
        if (raw[dw-1:0] == '0) begin
            raw[0] = 1'b1;
        end
        return raw[dw-1:0];
    endfunction

    function automatic void model_event(input int row, input int col,
                                        input logic [dw-1:0] value,
                                        output bit dropped, output int advances);
        dropped  = 1'b0;
        advances = 0;
        if (row < model_base) begin
            dropped = 1'b1;
        end else begin
            while (row > model_base + 2 * hw && model_base < max_base) begin
                model_base++;
                advances++;
                // Row entering at the bottom starts cleared
                for (int c = 0; c < num_cols; c++) begin
                    model_mem[model_base + 2 * hw][c] = '0;
                end
            end
            model_mem[row][col] = value;
        end
    endfunction

    function automatic logic [dw-1:0] expected_pixel(input int row, input int col);
        if (row < model_base || row > model_base + 2 * hw || col < 0 || col >= num_cols) begin
            return '0;
        end
        return model_mem[row][col];
    endfunction

    // Starts and ends right after a falling edge
    task automatic send_event(input int row, input int col, input logic [dw-1:0] value);
        bit exp_drop;
        int advances;
        int exp_latency;
        int latency;
        int wait_cycles;
        bit finished;

        model_event(row, col, value, exp_drop, advances);
        exp_latency = 2 + advances;
        event_valid = 1'b1;
        event_addr  = {row[7:0], col[7:0]};
        event_value = value;
        wait_cycles = 0;
        while (!event_ready && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!event_ready) begin
            error_count++;
            $display("Event at row %0d col %0d was never accepted", row, col);
            event_valid = 1'b0;
        end else begin
            // Accepted on the coming rising edge
            @(negedge clk);
            event_valid = 1'b0;
            latency     = 1;
            finished    = 1'b0;
            while (!finished) begin
                compare_value("event_ready", 64'(event_ready), 64'd0);
                if (write_done || event_dropped) begin
                    finished = 1'b1;
                end else if (latency > exp_latency + 4) begin
                    error_count++;
                    $display("No write_done or event_dropped for event at row %0d", row);
                    finished = 1'b1;
                end else begin
                    @(negedge clk);
                    latency++;
                end
            end
            compare_value("event latency", 64'(latency), 64'(exp_latency));
            compare_value("write_done", 64'(write_done), 64'(!exp_drop));
            compare_value("event_dropped", 64'(event_dropped), 64'(exp_drop));
            @(negedge clk);
            compare_value("event_ready", 64'(event_ready), 64'd1);
            compare_value("write_done", 64'(write_done), 64'd0);
            compare_value("event_dropped", 64'(event_dropped), 64'd0);
        end
    endtask

    task automatic verify_window(input int row, input int col);
        logic [dw-1:0] expected;
        compare_value("window_valid", 64'(window_valid), 64'd1);
        for (int r = 0; r < ws; r++) begin
            for (int k = 0; k < ws; k++) begin
                expected = expected_pixel(row - hw + r, col - hw + k);
                compare_value($sformatf("window_value[%0d][%0d] at (%0d,%0d)", r, k, row, col),
                              64'(window_value[r][k]), 64'(expected));
            end
        end
    endtask

    task automatic read_window(input int row, input int col);
        read_req  = 1'b1;
        read_addr = {row[7:0], col[7:0]};
        @(negedge clk);
        read_req = 1'b0;
        verify_window(row, col);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_state();
        compare_value("event_ready", 64'(event_ready), 64'd1);
        compare_value("write_done", 64'(write_done), 64'd0);
        compare_value("event_dropped", 64'(event_dropped), 64'd0);
        compare_value("window_valid", 64'(window_valid), 64'd0);
        read_window(0, 0);
        read_window(2, 128);
        read_window(4, 255);
        read_window(200, 17);
    endtask

    task automatic write_in_band();
        int edge_cols [4];
        int mid_col;
        edge_cols = '{0, 1, 254, 255};
        mid_col   = $urandom_range(num_cols - 3, 2);
        for (int r = 0; r <= 2 * hw; r++) begin
            send_event(r, edge_cols[r % 4], rand_value());
        end
        send_event(2, mid_col, rand_value());
        // Overwrite of a stored pixel
        send_event(0, 0, rand_value());
        read_window(0, 0);
        read_window(0, 255);
        read_window(1, 1);
        read_window(2, mid_col);
        read_window(4, 254);
        read_window(4, 255);
        read_window(2, 0);
    endtask

    task automatic advance_band();
        adv_col = $urandom_range(num_cols - 3, 2);
        send_event(9, adv_col, rand_value());
        read_window(9, adv_col);
        read_window(7, adv_col);
        // Slots reused from rows 0 and 4 must read as cleared
        read_window(6, 1);
        read_window(9, 1);
        read_window(7, 255);
        read_window(5, 0);
        read_window(2, 0);
    endtask

    task automatic drop_above_band();
        send_event(4, 10, rand_value());
        send_event(0, adv_col, rand_value());
        read_window(9, adv_col);
        read_window(5, 10);
    endtask

    task automatic read_back_to_back();
        int wcols [4];
        int rows [8];
        int cols [8];
        for (int i = 0; i < 4; i++) begin
            wcols[i] = $urandom_range(num_cols - 2, 0);
            send_event(5 + i, wcols[i], rand_value());
        end
        for (int i = 0; i < 8; i++) begin
            rows[i] = 3 + i;
            cols[i] = wcols[i % 4] + i / 4;
        end
        read_req = 1'b1;
        for (int i = 0; i < 8; i++) begin
            read_addr = {rows[i][7:0], cols[i][7:0]};
            @(negedge clk);
            verify_window(rows[i], cols[i]);
        end
        read_req = 1'b0;
        @(negedge clk);
        compare_value("window_valid", 64'(window_valid), 64'd0);
    endtask

    task automatic saturate_base();
        int sat_col;
        sat_col = $urandom_range(num_cols - 1, 0);
        send_event(255, sat_col, rand_value());
        send_event(253, 0, rand_value());
        send_event(251, 255, rand_value());
        send_event(255, sat_col, rand_value());
        // Band stops at 251, so row 250 is above it
        send_event(250, 3, rand_value());
        read_window(253, sat_col);
        read_window(253, 0);
        read_window(251, 255);
        read_window(255, sat_col);
        read_window(249, 2);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        event_valid = 1'b0;
        event_value = '0;
        event_addr  = '0;
        read_req    = 1'b0;
        read_addr   = '0;
        error_count = 0;
        check_count = 0;
        model_base  = 0;
        adv_col     = 0;
        for (int r = 0; r < num_rows; r++) begin
            for (int c = 0; c < num_cols; c++) begin
                model_mem[r][c] = '0;
            end
        end
        void'($urandom(32'hc99));

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        write_in_band();
        advance_band();
        drop_above_band();
        read_back_to_back();
        saturate_base();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("Run did not finish within %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
event_geom_pkg.sv
window_pkg.sv
row_base_counter.sv
write_fsm.sv
row_ring_buffer.sv
window_gather.sv
event_window_top.sv
tb_event_window.sv

// File: window_gather.sv
`timescale 1ns/100ps
`default_nettype none

module window_gather #(
    parameter int  DATA_WIDTH  = event_geom_pkg::default_data_width,
    parameter int  HALF_WINDOW = window_pkg::default_half_window,
    localparam int WINDOW_SIZE = 2 * HALF_WINDOW + 1,
    localparam int SLOT_WIDTH  = $clog2(WINDOW_SIZE)
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  read_req,
    input  wire [event_geom_pkg::addr_width-1:0] read_addr,
    input  wire event_geom_pkg::coord_t          base_row,
    input  wire [SLOT_WIDTH-1:0]                 head_slot,
    input  wire [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] rd_rows,
    output event_geom_pkg::coord_t               rd_col,
    // Row-major, window_value[0][0] in the top bits
    output logic [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] window_value,
    output logic                                 window_valid
);

    localparam int CW = event_geom_pkg::coord_width;
    localparam int AW = event_geom_pkg::addr_width;

    logic [0:WINDOW_SIZE-1][0:WINDOW_SIZE-1][DATA_WIDTH-1:0] window_next;
    event_geom_pkg::coord_t read_row;

    assign read_row = read_addr[AW-1:CW];
    assign rd_col   = read_addr[CW-1:0];

    // Map each window row onto its ring slot
    always_comb begin
        int src;
        int slot;
        src  = 0;
        slot = 0;
        for (int r = 0; r < WINDOW_SIZE; r++) begin
            src  = int'(read_row) - HALF_WINDOW + r;
            slot = int'(head_slot) + src - int'(base_row);
            if (slot >= WINDOW_SIZE) begin
                slot = slot - WINDOW_SIZE;
            end
            if (src >= int'(base_row) && src <= int'(base_row) + 2 * HALF_WINDOW) begin
                window_next[r] = rd_rows[slot[SLOT_WIDTH-1:0]];
            end else begin
                window_next[r] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (read_req) begin
            window_value <= window_next;
        end
    end

endmodule

`default_nettype wire

// File: window_pkg.sv
`default_nettype none

package window_pkg;

    // 5x5 neighborhood by default
    localparam int default_half_window = 2;

    // Highest base row that keeps the band on the sensor
    localparam int max_base_row = 251;

    typedef enum logic [1:0] {
        idle    = 2'd0,
        advance = 2'd1,
        write   = 2'd2
    } write_state_t;

endpackage

`default_nettype wire

// File: write_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module write_fsm #(
    parameter int  DATA_WIDTH  = event_geom_pkg::default_data_width,
    parameter int  HALF_WINDOW = window_pkg::default_half_window,
    localparam int WINDOW_SIZE = 2 * HALF_WINDOW + 1,
    localparam int SLOT_WIDTH  = $clog2(WINDOW_SIZE)
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  event_valid,
    input  wire [DATA_WIDTH-1:0]                 event_value,
    input  wire [event_geom_pkg::addr_width-1:0] event_addr,
    output logic                                 event_ready,
    input  wire event_geom_pkg::coord_t          base_row,
    input  wire [SLOT_WIDTH-1:0]                 head_slot,
    output logic                                 advance,
    output logic                                 wr_en,
    output logic [SLOT_WIDTH-1:0]                wr_slot,
    output event_geom_pkg::coord_t               wr_col,
    output logic [DATA_WIDTH-1:0]                wr_value,
    output logic                                 clr_en,
    output logic [SLOT_WIDTH-1:0]                clr_slot,
    output logic                                 write_done,
    output logic                                 event_dropped
);

    localparam int CW = event_geom_pkg::coord_width;
    localparam int AW = event_geom_pkg::addr_width;

    window_pkg::write_state_t state;
    logic                     pending;
    logic                     accept;
    logic                     row_dropped;
    logic                     need_advance;
    logic                     row_reached;
    event_geom_pkg::coord_t   evt_row;
    event_geom_pkg::coord_t   evt_col;
    logic [DATA_WIDTH-1:0]    evt_value;

    assign event_ready = (state == window_pkg::idle) && !pending && !event_dropped;
    assign accept      = event_valid && event_ready;

    // Event row against the current band
    assign row_dropped  = evt_row < base_row;
    assign need_advance = int'(evt_row) > int'(base_row) + 2 * HALF_WINDOW;
    // True when the advance in flight makes evt_row the last band row
    assign row_reached  = int'(evt_row) <= int'(base_row) + 2 * HALF_WINDOW + 1;

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= window_pkg::idle;
            pending       <= 1'b0;
            event_dropped <= 1'b0;
        end else begin
            event_dropped <= 1'b0;
            case (state)
                window_pkg::idle: begin
                    if (pending) begin
                        pending <= 1'b0;
                        if (row_dropped) begin
                            event_dropped <= 1'b1;
                        end else if (need_advance) begin
                            state <= window_pkg::advance;
                        end else begin
                            state <= window_pkg::write;
                        end
                    end else if (accept) begin
                        pending <= 1'b1;
                    end
                end
                window_pkg::advance: begin
                    if (row_reached) begin
                        state <= window_pkg::write;
                    end
                end
                window_pkg::write: begin
                    state <= window_pkg::idle;
                end
                default: begin
                    state <= window_pkg::idle;
                end
            endcase
        end
    end

    // Event held until it is stored or dropped
    always_ff @(posedge clk) begin
        if (accept) begin
            evt_row   <= event_addr[AW-1:CW];
            evt_col   <= event_addr[CW-1:0];
            evt_value <= event_value;
        end
    end

    //////////////////////////////
    // Buffer strobes
    //////////////////////////////

    // Old head slot becomes the new last row
    assign advance  = state == window_pkg::advance;
    assign clr_en   = state == window_pkg::advance;
    assign clr_slot = head_slot;

    assign wr_en      = state == window_pkg::write;
    assign write_done = state == window_pkg::write;
    assign wr_col     = evt_col;
    assign wr_value   = evt_value;

    always_comb begin
        int sum;
        sum = int'(head_slot) + int'(evt_row - base_row);
        if (sum >= WINDOW_SIZE) begin
            sum = sum - WINDOW_SIZE;
        end
        wr_slot = sum[SLOT_WIDTH-1:0];
    end

endmodule

`default_nettype wire
